// File: ex_mem.f
logic/ex_mem_pkg.sv
logic/exec_unit.sv
logic/ex_mem_reg.sv
logic/mem_access.sv
logic/ex_mem_top.sv
dv/ex_mem_chk.sv
dv/ex_mem_scoreboard.sv
dv/ex_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= ex_mem_tb
FILELIST  ?= ex_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/ex_mem_tb.sv
`timescale 1ns/1ps
//--------------------
// Random tests of the EX/MEM back half, seed 47164.
// Memory loads only hit words written in the store test.
//--------------------
module ex_mem_tb;
    import ex_mem_pkg::*;

    logic      clk = 1'b0;
    logic      i_rst_n;
    ex_req_t   i_req;
    logic      i_req_valid;
    logic      o_req_ready;
    logic      i_flush;
    wb_t       o_wb;
    logic      o_wb_valid;
    logic      i_wb_ready;
    redirect_t o_redirect;
    int        seed = 47164;
    int        sb_errors;
    int        sb_checks;
    logic      sb_idle;
    logic      bp_en = 1'b0;
    logic      flush_en = 1'b0;
    logic      ready_nxt;
    logic      flush_nxt;
    logic      hung = 1'b0;
    string     hung_why;
    int        tb_errors = 0;
    int        e0;
    int        off;
    int        words[$];
    ex_req_t   r;
    logic [2:0] f3s [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

    always #4 clk = !clk;

    ex_mem_top #(.DATA_WIDTH(32), .MEM_DEPTH(256)) i_dut (
        .clk(clk), .i_rst_n(i_rst_n), .i_req(i_req), .i_req_valid(i_req_valid),
        .o_req_ready(o_req_ready), .i_flush(i_flush), .o_wb(o_wb),
        .o_wb_valid(o_wb_valid), .i_wb_ready(i_wb_ready), .o_redirect(o_redirect)
    );

    ex_mem_scoreboard #(.MEM_DEPTH(256)) i_sb (
        .clk(clk), .i_rst_n(i_rst_n), .i_req(i_req), .i_req_valid(i_req_valid),
        .i_req_ready(o_req_ready), .i_flush(i_flush), .i_wb(o_wb),
        .i_wb_valid(o_wb_valid), .i_wb_ready(i_wb_ready), .i_redirect(o_redirect),
        .o_errors(sb_errors), .o_checks(sb_checks), .o_idle(sb_idle)
    );

    // Back-pressure and flush patterns, drawn at the edge and driven 1 ns later
    always @(posedge clk) begin
        ready_nxt = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
        flush_nxt = flush_en ? (($random(seed) & 7) == 0) : 1'b0;
        #1;
        i_wb_ready = ready_nxt;
        i_flush    = flush_nxt;
    end

    initial begin
        @(posedge hung);
        $display("Timeout: %s", hung_why);
        $display("TB FAILED");
        $finish;
    end

    task automatic give_up(input string why);
        hung_why = why;
        hung = 1'b1;
        forever @(posedge clk);
    endtask

    // Scoreboard, local and assertion failures together
    function automatic int error_total();
        return sb_errors + tb_errors + i_dut.i_chk.fail_count;
    endfunction

    task automatic send(input ex_req_t req);
        int  waited;
        logic acc;
        waited = 0;
        acc = 1'b0;
        i_req = req;
        i_req_valid = 1'b1;
        while (!acc) begin
            @(negedge clk) acc = o_req_ready;
            @(posedge clk) #1;
            waited++;
            if (waited > 1000) give_up("request was never accepted");
        end
        i_req_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 1000) give_up("pipeline did not drain");
        end while (!sb_idle);
        @(posedge clk) #1;
    endtask

    function automatic ex_req_t mem_req(int addr, logic [31:0] d, logic st, logic [2:0] f3);
        ex_req_t q;
        q = '0;
        q.alu_op = ALU_ADD;
        q.op_a = addr;
        q.store_data = d;
        q.func3 = f3;
        q.size = size_e'(f3[1:0]);
        q.rd = 5'($random(seed));
        q.ctrl.mem_write = st;
        q.ctrl.mem_read = !st;
        q.ctrl.mem_to_reg = !st;
        q.ctrl.reg_write = !st;
        return q;
    endfunction

    function automatic ex_req_t alu_req();
        ex_req_t q;
        q = '0;
        q.alu_op = alu_op_e'(4'((($random(seed)) & 32'h7fff_ffff) % 11));
        q.op_a = $random(seed);
        q.op_b = $random(seed);
        q.rd = 5'($random(seed));
        q.ctrl.reg_write = 1'b1;
        return q;
    endfunction

    initial begin
        i_rst_n = 1'b0;
        i_req = '0;
        i_req_valid = 1'b0;
        i_flush = 1'b0;
        i_wb_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1 i_rst_n = 1'b1;

        e0 = error_total();
        repeat (40) send(alu_req());
        drain();
        $display("test 1 alu ops: %0d errors", error_total() - e0);

        e0 = error_total();
        for (int i = 0; i < 12; i++) begin
            words.push_back($random(seed) & 255);
            send(mem_req(words[i] * 4, $random(seed), 1'b1, 3'b010));
            off = (i & 1) ? ($random(seed) & 2) : ($random(seed) & 3);
            send(mem_req(words[i] * 4 + off, $random(seed), 1'b1, (i & 1) ? 3'b001 : 3'b000));
            foreach (f3s[k]) begin
                off = f3s[k][1] ? 0 : f3s[k][0] ? ($random(seed) & 2) : ($random(seed) & 3);
                send(mem_req(words[i] * 4 + off, 0, 1'b0, f3s[k]));
            end
        end
        drain();
        $display("test 2 stores and loads: %0d errors", error_total() - e0);

        e0 = error_total();
        for (int i = 0; i < 30; i++) begin
            r = '0;
            r.op_a = $random(seed);
            r.op_b = (i % 3 == 0) ? r.op_a : $random(seed);
            r.pc = $random(seed) & ~32'd3;
            r.imm = $random(seed) & ~32'd1;
            r.func3 = 3'($random(seed));
            r.rd = 5'($random(seed));
            if (i % 4 == 0) begin
                r.jump_target = $random(seed) & ~32'd3;
                r.ctrl.jump = 1'b1;
                r.ctrl.link_reg = 1'b1;
                r.ctrl.reg_write = 1'b1;
            end else begin
                r.ctrl.branch = 1'b1;
            end
            send(r);
        end
        drain();
        $display("test 3 branches and jumps: %0d errors", error_total() - e0);

        e0 = error_total();
        bp_en = 1'b1;
        repeat (60) send(alu_req());
        drain();
        bp_en = 1'b0;
        $display("test 4 back-pressure: %0d errors", error_total() - e0);

        e0 = error_total();
        bp_en = 1'b1;
        flush_en = 1'b1;
        for (int i = 0; i < 60; i++) begin
            if (i % 3 == 0) send(mem_req(words[i % 12] * 4, $random(seed), 1'b1, 3'b010));
            else send(alu_req());
        end
        flush_en = 1'b0;
        bp_en = 1'b0;
        drain();
        foreach (words[i]) send(mem_req(words[i] * 4, 0, 1'b0, 3'b010));
        drain();
        $display("test 5 flush: %0d errors", error_total() - e0);

        e0 = error_total();
        i_req = alu_req();
        i_req_valid = 1'b1;
        @(posedge clk) #1;
        i_req_valid = 1'b0;
        i_rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 i_rst_n = 1'b1;
        @(negedge clk);
        if (o_wb_valid !== 1'b0 || o_redirect.taken !== 1'b0 || o_req_ready !== 1'b1) begin
            tb_errors++;
            $display("MISMATCH @%0t: outputs not idle after reset", $time);
        end
        $display("test 6 reset: %0d errors", error_total() - e0);

        $display("6 tests, %0d checks, %0d errors", sb_checks, error_total());
        if (error_total() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: dv/ex_mem_scoreboard.sv
`timescale 1ns/1ps
//--------------------
// Cycle model of the handshake, ALU, memory and writeback.
// Loads must only touch words that were stored before.
//--------------------
module ex_mem_scoreboard import ex_mem_pkg::*; #(
    parameter int MEM_DEPTH = 256
) (
    input  logic      clk,
    input  logic      i_rst_n,
    input  ex_req_t   i_req,
    input  logic      i_req_valid,
    input  logic      i_req_ready,
    input  logic      i_flush,
    input  wb_t       i_wb,
    input  logic      i_wb_valid,
    input  logic      i_wb_ready,
    input  redirect_t i_redirect,
    output int        o_errors,
    output int        o_checks,
    output logic      o_idle
);

    logic [31:0] mem_m [MEM_DEPTH];
    ex_req_t     reg_req;
    logic        reg_v;
    logic        wb_v;
    logic        mem_rdy;
    logic        req_rdy;
    logic        mem_acc;
    logic        exp_taken;
    wb_t         exp_q[$];
    wb_t         exp_wb;
    logic [31:0] addr;
    logic [31:0] ld;
    int          idx;

    function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_XOR:   return a ^ b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return $signed(a) >>> b[4:0];
            ALU_SLT:   return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:  return {31'b0, a < b};
            ALU_PASSB: return b;
            default:   return '0;
        endcase
    endfunction

    function automatic logic cond_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] load_model(logic [31:0] w, logic [1:0] off, logic [2:0] f3);
        logic [31:0] sh;
        sh = w >> (off * 8);
        case (f3[1:0])
            2'b00:   return f3[2] ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            2'b01:   return f3[2] ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] store_model(logic [31:0] w, logic [1:0] off,
                                                size_e sz, logic [31:0] d);
        logic [31:0] mask;
        case (sz)
            SIZE_BYTE: mask = 32'hff << (off * 8);
            SIZE_HALF: mask = 32'hffff << (off[1] * 16);
            default:   mask = 32'hffff_ffff;
        endcase
        return (w & ~mask) | ((d << (sz == SIZE_HALF ? off[1] * 16 : off * 8)) & mask);
    endfunction

    task automatic report(input string msg);
        o_errors++;
        $display("MISMATCH @%0t: %s", $time, msg);
    endtask

    initial begin
        o_errors = 0;
        o_checks = 0;
    end

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reg_v = 1'b0;
            wb_v  = 1'b0;
            exp_q.delete();
        end else begin
            mem_rdy = !wb_v || i_wb_ready;
            req_rdy = !reg_v || mem_rdy;
            mem_acc = reg_v && !i_flush && mem_rdy;
            if (i_req_ready !== req_rdy) report("o_req_ready differs from model");
            if (i_wb_valid !== wb_v) report("o_wb_valid differs from model");
            exp_taken = mem_acc && (reg_req.ctrl.jump || (reg_req.ctrl.branch &&
                        cond_model(reg_req.func3, reg_req.op_a, reg_req.op_b)));
            o_checks++;
            if (i_redirect.taken !== exp_taken) begin
                report($sformatf("redirect taken %b, expected %b", i_redirect.taken, exp_taken));
            end else if (exp_taken) begin
                addr = reg_req.ctrl.jump ? reg_req.jump_target : reg_req.pc + reg_req.imm;
                if (i_redirect.target !== addr) begin
                    report($sformatf("redirect target %h, expected %h", i_redirect.target, addr));
                end
            end
            if (i_wb_valid && i_wb_ready) begin
                o_checks++;
                if (exp_q.size() == 0) begin
                    report("writeback with no expected entry");
                end else begin
                    exp_wb = exp_q.pop_front();
                    if (i_wb !== exp_wb) begin
                        report($sformatf("wb rd %0d data %h we %b, expected rd %0d data %h we %b",
                               i_wb.rd, i_wb.data, i_wb.reg_write,
                               exp_wb.rd, exp_wb.data, exp_wb.reg_write));
                    end
                end
            end
            if (mem_acc) begin
                addr = alu_model(reg_req.alu_op, reg_req.op_a, reg_req.op_b);
                idx  = (addr >> 2) % MEM_DEPTH;
                ld   = reg_req.ctrl.mem_read ? load_model(mem_m[idx], addr[1:0], reg_req.func3) : '0;
                if (reg_req.ctrl.mem_write) begin
                    mem_m[idx] = store_model(mem_m[idx], addr[1:0], reg_req.size,
                                             reg_req.store_data);
                end
                exp_wb.rd        = reg_req.rd;
                exp_wb.reg_write = reg_req.ctrl.reg_write;
                exp_wb.data      = reg_req.ctrl.link_reg ? reg_req.pc + 32'd4 :
                                   reg_req.ctrl.mem_to_reg ? ld : addr;
                exp_q.push_back(exp_wb);
                wb_v = 1'b1;
            end else if (i_wb_ready) begin
                wb_v = 1'b0;
            end
            if (i_flush) begin
                reg_v = 1'b0;   // Held entry and same-cycle request both dropped
            end else if (req_rdy) begin
                reg_v = i_req_valid;
                if (i_req_valid) reg_req = i_req;
            end
        end
        o_idle = !reg_v && !wb_v && (exp_q.size() == 0);
    end

endmodule

// File: dv/ex_mem_chk.sv
`timescale 1ns/1ps
//--------------------
// Bound into ex_mem_top, sees its ports and the EX/MEM valid.
// Checks writeback stability, flush and reset.
//--------------------
module ex_mem_chk import ex_mem_pkg::*; (
    input logic      clk,
    input logic      i_rst_n,
    input logic      i_flush,
    input logic      i_reg_valid,
    input logic      i_req_ready,
    input wb_t       i_wb,
    input logic      i_wb_valid,
    input logic      i_wb_ready,
    input redirect_t i_redirect
);

    int fail_count = 0;    // Failed assertions so far

    // Stalled writeback holds its payload
    a_wb_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wb_valid && !i_wb_ready |=> i_wb_valid && $stable(i_wb))
        else begin
            $error("writeback changed while stalled");
            fail_count++;
        end

    a_flush_clears: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_flush |=> !i_reg_valid)
        else begin
            $error("EX/MEM entry survived a flush");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge clk)
        !i_rst_n |-> !i_wb_valid && !i_redirect.taken && i_req_ready)
        else begin
            $error("outputs active during reset");
            fail_count++;
        end

endmodule

bind ex_mem_top ex_mem_chk i_chk (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_flush     (i_flush),
    .i_reg_valid (ex_q_valid),
    .i_req_ready (o_req_ready),
    .i_wb        (o_wb),
    .i_wb_valid  (o_wb_valid),
    .i_wb_ready  (i_wb_ready),
    .i_redirect  (o_redirect)
);

// File: logic/ex_mem_top.sv
`timescale 1ns/1ps
//--------------------
// Execute, EX/MEM register and memory stage in series.
// Two cycles from request to writeback without back-pressure.
// Flush is external, there is no hazard logic here.
//--------------------
module ex_mem_top import ex_mem_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int MEM_DEPTH  = 256
) (
    input  logic      clk,
    input  logic      i_rst_n,
    input  ex_req_t   i_req,
    input  logic      i_req_valid,
    output logic      o_req_ready,
    input  logic      i_flush,
    output wb_t       o_wb,
    output logic      o_wb_valid,
    input  logic      i_wb_ready,
    output redirect_t o_redirect
);

    ex_mem_t ex_comb;     // Execute result, same cycle
    ex_mem_t ex_q;        // Registered entry
    logic    ex_q_valid;
    logic    mem_ready;

    exec_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_exec (
        .i_req (i_req),
        .o_ex  (ex_comb)
    );

    ex_mem_reg i_ex_mem_reg (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_ex    (ex_comb),
        .i_valid (i_req_valid),
        .o_ready (o_req_ready),
        .o_ex    (ex_q),
        .o_valid (ex_q_valid),
        .i_ready (mem_ready)
    );

    mem_access #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_mem_access (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_ex       (ex_q),
        .i_valid    (ex_q_valid),
        .o_ready    (mem_ready),
        .o_wb       (o_wb),
        .o_wb_valid (o_wb_valid),
        .i_wb_ready (i_wb_ready),
        .o_redirect (o_redirect)
    );

endmodule

// File: logic/mem_access.sv
`timescale 1ns/1ps
//--------------------
// Data memory with async read, MEM_DEPTH words, a power of two.
// Accesses are assumed aligned to their size.
// Each accepted entry makes one writeback, reg_write marks if it counts.
//--------------------
module mem_access import ex_mem_pkg::*; #(
    parameter int MEM_DEPTH = 256
) (
    input  logic      clk,
    input  logic      i_rst_n,
    input  ex_mem_t   i_ex,
    input  logic      i_valid,
    output logic      o_ready,
    output wb_t       o_wb,
    output logic      o_wb_valid,
    input  logic      i_wb_ready,
    output redirect_t o_redirect
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [XLEN-1:0]  mem [MEM_DEPTH];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_sel;
    logic             half_sel;
    mem_word_u        rd_word;
    mem_word_u        st_word;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;
    logic             ld_unsigned;
    logic [XLEN-1:0]  load_data;
    logic [XLEN-1:0]  wb_data;
    logic             accept;
    logic             wb_valid_q;
    wb_t              wb_q;

    assign o_ready = !wb_valid_q || i_wb_ready;
    assign accept  = i_valid && o_ready;

    // Word index wraps modulo MEM_DEPTH
    assign word_idx = i_ex.alu[IDX_W+1:2];
    assign byte_sel = i_ex.alu[1:0];
    assign half_sel = i_ex.alu[1];
    assign rd_word  = mem[word_idx];

    // Store merge into the selected lanes
    always_comb begin
        st_word = rd_word;
        case (i_ex.size)
            SIZE_BYTE: st_word.b[byte_sel] = i_ex.data2[7:0];
            SIZE_HALF: st_word.h[half_sel] = i_ex.data2[15:0];
            default:   st_word = i_ex.data2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept && i_ex.ctrl.mem_write) begin
            mem[word_idx] <= st_word;
        end
    end

    assign ld_byte     = rd_word.b[byte_sel];
    assign ld_half     = rd_word.h[half_sel];
    assign ld_unsigned = i_ex.func3[2];    // LBU / LHU

    always_comb begin
        load_data = '0;
        if (i_ex.ctrl.mem_read) begin
            case (i_ex.size)
                SIZE_BYTE: begin
                    load_data = ld_unsigned ? {{(XLEN-8){1'b0}}, ld_byte}
                                            : {{(XLEN-8){ld_byte[7]}}, ld_byte};
                end
                SIZE_HALF: begin
                    load_data = ld_unsigned ? {{(XLEN-16){1'b0}}, ld_half}
                                            : {{(XLEN-16){ld_half[15]}}, ld_half};
                end
                default: load_data = rd_word;
            endcase
        end
    end

    // Link beats load beats ALU
    always_comb begin
        if (i_ex.ctrl.link_reg) begin
            wb_data = i_ex.pc_next;
        end else if (i_ex.ctrl.mem_to_reg) begin
            wb_data = load_data;
        end else begin
            wb_data = i_ex.alu;
        end
    end

    // Redirect is a single-cycle pulse on acceptance
    always_comb begin
        o_redirect.taken  = accept && (i_ex.ctrl.jump || (i_ex.ctrl.branch && i_ex.cond));
        o_redirect.target = i_ex.ctrl.jump ? i_ex.jump_addr : i_ex.branch_addr;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_valid_q <= 1'b0;
        end else if (accept) begin
            wb_valid_q <= 1'b1;
        end else if (i_wb_ready) begin
            wb_valid_q <= 1'b0;            // Drained
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_q.rd        <= i_ex.rd;
            wb_q.data      <= wb_data;
            wb_q.reg_write <= i_ex.ctrl.reg_write;
        end
    end

    assign o_wb       = wb_q;
    assign o_wb_valid = wb_valid_q;

endmodule

// File: logic/ex_mem_reg.sv
`timescale 1ns/1ps
//--------------------
// EX/MEM register with valid/ready handshake.
// Flush drops the held entry and any entry loaded in the same cycle.
// Payload is not cleared, valid gates its use.
//--------------------
module ex_mem_reg import ex_mem_pkg::*; (
    input  logic    clk,
    input  logic    i_rst_n,
    input  logic    i_flush,
    input  ex_mem_t i_ex,
    input  logic    i_valid,
    output logic    o_ready,
    output ex_mem_t o_ex,
    output logic    o_valid,
    input  logic    i_ready
);

    logic    valid_q;
    ctrl_t   ctrl_q;
    ex_mem_t data_q;
    logic    load;

    // Free slot when empty or when the entry leaves this cycle
    assign o_ready = !valid_q || i_ready;
    assign load    = i_valid && o_ready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
        end else if (i_flush) begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
        end else if (o_ready) begin
            valid_q <= i_valid;
            if (i_valid) begin
                ctrl_q <= i_ex.ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= i_ex;
        end
    end

    // Flags come from the cleared copy
    always_comb begin
        o_ex      = data_q;
        o_ex.ctrl = ctrl_q;
    end

    // Held entry must not reach memory while being flushed
    assign o_valid = valid_q && !i_flush;

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps
//--------------------
// Combinational execute stage, no state and no latency.
// DATA_WIDTH must equal ex_mem_pkg::XLEN.
// Shifts use only the low log2(DATA_WIDTH) bits of op_b.
//--------------------
module exec_unit import ex_mem_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  ex_req_t i_req,
    output ex_mem_t o_ex
);

    localparam int SHAMT_W = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    logic [SHAMT_W-1:0]    shamt;
    logic [DATA_WIDTH-1:0] alu_res;
    logic [DATA_WIDTH-1:0] pc_plus4;
    logic [DATA_WIDTH-1:0] br_target;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic                  eq;
    logic                  cond;

    assign op_a  = i_req.op_a;
    assign op_b  = i_req.op_b;
    assign shamt = op_b[SHAMT_W-1:0];

    // Shared by the ALU set ops and the branch compare
    assign eq          = (op_a == op_b);
    assign lt_signed   = ($signed(op_a) < $signed(op_b));
    assign lt_unsigned = (op_a < op_b);

    always_comb begin
        case (i_req.alu_op)
            ALU_ADD:   alu_res = op_a + op_b;
            ALU_SUB:   alu_res = op_a - op_b;
            ALU_AND:   alu_res = op_a & op_b;
            ALU_OR:    alu_res = op_a | op_b;
            ALU_XOR:   alu_res = op_a ^ op_b;
            ALU_SLL:   alu_res = op_a << shamt;
            ALU_SRL:   alu_res = op_a >> shamt;
            ALU_SRA:   alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:   alu_res = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
            ALU_SLTU:  alu_res = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
            ALU_PASSB: alu_res = op_b;     // LUI style pass-through
            default:   alu_res = '0;
        endcase
    end

    // Branch condition from func3
    always_comb begin
        case (i_req.func3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt_signed;
            F3_BGE:  cond = !lt_signed;
            F3_BLTU: cond = lt_unsigned;
            F3_BGEU: cond = !lt_unsigned;
            default: cond = 1'b0;          // 010/011 are not branches
        endcase
    end

    assign pc_plus4  = i_req.pc + DATA_WIDTH'(4);
    assign br_target = i_req.pc + i_req.imm;

    always_comb begin
        o_ex.alu         = alu_res;
        o_ex.data2       = i_req.store_data;
        o_ex.pc_next     = pc_plus4;
        o_ex.branch_addr = br_target;
        o_ex.jump_addr   = i_req.jump_target;  // Already computed upstream
        o_ex.cond        = cond;
        o_ex.rd          = i_req.rd;
        o_ex.func3       = i_req.func3;
        o_ex.size        = i_req.size;
        o_ex.ctrl        = i_req.ctrl;
    end

endmodule

// File: logic/ex_mem_pkg.sv
//--------------------
// Shared types for the EX/MEM back half of the pipeline.
// XLEN has to match the DATA_WIDTH set at the top level.
// Size codes follow the RV32I load/store func3 low bits.
//--------------------
package ex_mem_pkg;

    localparam int XLEN = 32;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB
    } alu_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    // Branch compare encodings
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Control flags that travel with an instruction
    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic branch;
        logic jump;
        logic link_reg;
    } ctrl_t;

    typedef struct packed {
        alu_op_e         alu_op;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
        logic [XLEN-1:0] store_data;
        logic [XLEN-1:0] imm;          // Branch offset
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] jump_target;
        logic [4:0]      rd;
        logic [2:0]      func3;
        ctrl_t           ctrl;
        size_e           size;
    } ex_req_t;

    typedef struct packed {
        logic [XLEN-1:0] alu;
        logic [XLEN-1:0] data2;        // Store data
        logic [XLEN-1:0] pc_next;      // PC+4 for links
        logic [XLEN-1:0] branch_addr;
        logic [XLEN-1:0] jump_addr;
        logic            cond;         // Branch compare result
        logic [4:0]      rd;
        logic [2:0]      func3;
        size_e           size;
        ctrl_t           ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic            reg_write;
    } wb_t;

    typedef struct packed {
        logic [XLEN-1:0] target;
        logic            taken;
    } redirect_t;

    // One memory word, seen as byte lanes or half lanes
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage
